// ==== bench/lsu_store_unit_tb.sv ====
// Testbench for the store path, with a small ROB model that retires stores in order.
// A table of operations is applied in a loop and memory is checked through loads
// against a reference byte memory that is filled before the run starts.

module lsu_store_unit_tb;
    import lsu_pkg::*;

    localparam int SQ_DEPTH       = 4;
    localparam int RAM_WORDS      = 16;
    localparam int RAM_BYTES      = RAM_WORDS * 4;
    localparam int N_OPS          = 13;
    localparam int TIMEOUT_CYCLES = N_OPS * 40 + 100;
    localparam int POLL_CYCLES    = 20;
    localparam int BURST_CYCLES   = 6;

    typedef enum logic [1:0] {
        OP_STORE,
        OP_FLUSH,
        OP_BURST,
        OP_FILL
    } op_kind_t;

    // One table entry
    // A flush entry uses data[1] for the store that gets flushed and a fill uses all four
    typedef struct packed {
        op_kind_t         kind;
        lsu_func_t        func;
        addr_t            addr;
        logic [3:0][31:0] data;
        data_t            old_word;
        data_t            exp_word;
    } op_t;

    logic      clk;
    logic      n_rst;
    logic      i_flush;
    logic      o_full;
    logic      i_alloc_en;
    lsu_func_t i_alloc_func;
    tag_t      i_alloc_tag;
    addr_t     i_alloc_addr;
    data_t     i_alloc_data;
    logic      i_rob_retire_en;
    tag_t      i_rob_retire_tag;
    logic      o_rob_retire_ack;
    logic      i_load_en;
    addr_t     i_load_addr;
    data_t     o_load_data;

    op_t        ops [N_OPS];
    int         n_ops_added;
    logic [7:0] ref_mem [RAM_BYTES];
    logic [31:0] rng_state;
    tag_t       rob_q [$];
    tag_t       next_tag;
    logic       retire_at_edge;
    int         error_count;
    int         retire_count;
    int         ack_count;
    int         cycle_count;

    lsu_store_unit #(
        .SQ_DEPTH  (SQ_DEPTH),
        .RAM_WORDS (RAM_WORDS)
    ) i_lsu_store_unit (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .o_full           (o_full),
        .i_alloc_en       (i_alloc_en),
        .i_alloc_func     (i_alloc_func),
        .i_alloc_tag      (i_alloc_tag),
        .i_alloc_addr     (i_alloc_addr),
        .i_alloc_data     (i_alloc_data),
        .i_rob_retire_en  (i_rob_retire_en),
        .i_rob_retire_tag (i_rob_retire_tag),
        .o_rob_retire_ack (o_rob_retire_ack),
        .i_load_en        (i_load_en),
        .i_load_addr      (i_load_addr),
        .o_load_data      (o_load_data)
    );

    always #4 clk = ~clk;

    // The ack is registered from the retire request seen at the same edge
    always @(posedge clk) begin
        retire_at_edge <= i_rob_retire_en;
    end

    // Acks are counted mid-cycle, where they are stable
    always @(negedge clk) begin
        if (n_rst && o_rob_retire_ack) begin
            ack_count++;
            assert (retire_at_edge) else begin
                error_count++;
                $display("Retire ack at time %0t arrived with no retire pending", $time);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            error_count++;
            $display("Timeout after %0d cycles, the table did not finish", cycle_count);
            $display("Errors: %0d, retire acks: %0d of %0d", error_count, ack_count,
                     retire_count);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Applies the byte-lane rule of the store port to the reference memory
    function automatic void ref_write(input lsu_func_t func, input addr_t addr,
                                      input data_t data);
        int base;
        base = int'(addr % RAM_BYTES);
        case (func)
            LSU_SB: ref_mem[base] = data[7:0];
            LSU_SH: begin
                base = base & ~1;
                ref_mem[base]     = data[7:0];
                ref_mem[base + 1] = data[15:8];
            end
            default: begin
                base = base & ~3;
                for (int b = 0; b < 4; b++) begin
                    ref_mem[base + b] = data[b*8 +: 8];
                end
            end
        endcase
    endfunction

    function automatic data_t ref_word(input addr_t addr);
        int base;
        base = int'(addr % RAM_BYTES) & ~3;
        return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
    endfunction

    // Sub-stores of a fill entry overlap, so the final word depends on program order
    task automatic fill_pattern(input int k, output lsu_func_t func, output addr_t off);
        case (k)
            0: begin
                func = LSU_SW;
                off  = 32'd0;
            end
            1: begin
                func = LSU_SH;
                off  = 32'd2;
            end
            2: begin
                func = LSU_SB;
                off  = 32'd1;
            end
            default: begin
                func = LSU_SB;
                off  = 32'd2;
            end
        endcase
    endtask

    task automatic add_op(input op_kind_t kind, input lsu_func_t func, input addr_t addr);
        op_t e;
        e = '0;
        e.kind = kind;
        e.func = func;
        e.addr = addr;
        ops[n_ops_added] = e;
        n_ops_added++;
    endtask

    // Draws random data and computes expected words, walking the table in order
    task automatic build_expected();
        lsu_func_t func;
        addr_t     off;
        for (int i = 0; i < N_OPS; i++) begin
            ops[i].old_word = ref_word(ops[i].addr);
            if (ops[i].kind == OP_FILL) begin
                for (int k = 0; k < SQ_DEPTH; k++) begin
                    fill_pattern(k, func, off);
                    rng_state = xorshift(rng_state);
                    ops[i].data[k] = rng_state;
                    ref_write(func, ops[i].addr + off, rng_state);
                end
            end else begin
                // Redraw until the store really changes the word, so draining is visible
                do begin
                    rng_state = xorshift(rng_state);
                    ops[i].data[0] = rng_state;
                    ref_write(ops[i].func, ops[i].addr, rng_state);
                end while (ref_word(ops[i].addr) == ops[i].old_word);
                ops[i].data[1] = ~ops[i].data[0];
            end
            ops[i].exp_word = ref_word(ops[i].addr);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            error_count++;
            $display("Mismatch at time %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Each allocation is followed by an idle cycle so o_full is settled for the next
    task automatic alloc_store(input lsu_func_t func, input addr_t addr, input data_t data);
        assert (o_full === 1'b0) else begin
            error_count++;
            $display("Store queue full at time %0t when an allocation was due", $time);
        end
        i_alloc_en   = 1'b1;
        i_alloc_func = func;
        i_alloc_addr = addr;
        i_alloc_data = data;
        i_alloc_tag  = next_tag;
        rob_q.push_back(next_tag);
        next_tag++;
        tick();
        i_alloc_en = 1'b0;
        tick();
    endtask

    // ROB retires its oldest store and holds the request until the ack
    task automatic retire_oldest();
        tag_t tag;
        logic acked;
        acked = 1'b0;
        if (rob_q.size() == 0) begin
            error_count++;
            $display("ROB model had no store to retire at time %0t", $time);
        end else begin
            tag = rob_q.pop_front();
            i_rob_retire_en  = 1'b1;
            i_rob_retire_tag = tag;
            retire_count++;
            for (int c = 0; c < POLL_CYCLES && !acked; c++) begin
                tick();
                acked = o_rob_retire_ack;
            end
            i_rob_retire_en = 1'b0;
            assert (acked) else begin
                error_count++;
                $display("Store with tag %0d was never acked by time %0t", tag, $time);
            end
        end
    endtask

    task automatic load_word(input addr_t addr, output data_t got);
        i_load_en   = 1'b1;
        i_load_addr = addr;
        tick();
        i_load_en = 1'b0;
        got = o_load_data;
    endtask

    // Loads every other cycle, which cannot stay in step with the three-cycle retry loop
    task automatic poll_word(input addr_t addr, input data_t exp);
        data_t got;
        logic  seen;
        seen = 1'b0;
        got  = '0;
        for (int c = 0; c < POLL_CYCLES / 2 && !seen; c++) begin
            load_word(addr, got);
            seen = (got === exp);
            tick();
        end
        check_value("o_load_data", got, exp);
        tick();
    endtask

    task automatic run_op(input op_t op);
        lsu_func_t func;
        addr_t     off;
        data_t     got;
        case (op.kind)
            OP_STORE: begin
                alloc_store(op.func, op.addr, op.data[0]);
                retire_oldest();
                poll_word(op.addr, op.exp_word);
            end
            OP_FLUSH: begin
                // The first store is retired and in flight while the second one is flushed
                alloc_store(op.func, op.addr, op.data[0]);
                alloc_store(op.func, op.addr, op.data[1]);
                retire_oldest();
                i_flush = 1'b1;
                tick();
                i_flush = 1'b0;
                rob_q.delete();
                poll_word(op.addr, op.exp_word);
                repeat (6) tick();
                load_word(op.addr, got);
                check_value("o_load_data", got, op.exp_word);
            end
            OP_BURST: begin
                // Loads own the RAM, so the launched store keeps retrying
                i_load_en   = 1'b1;
                i_load_addr = op.addr;
                alloc_store(op.func, op.addr, op.data[0]);
                retire_oldest();
                for (int c = 0; c < BURST_CYCLES; c++) begin
                    tick();
                    check_value("o_load_data", o_load_data, op.old_word);
                end
                i_load_en = 1'b0;
                poll_word(op.addr, op.exp_word);
            end
            default: begin
                for (int k = 0; k < SQ_DEPTH; k++) begin
                    fill_pattern(k, func, off);
                    alloc_store(func, op.addr + off, op.data[k]);
                end
                check_value("o_full", o_full, 1'b1);
                retire_oldest();
                for (int c = 0; c < POLL_CYCLES && o_full; c++) begin
                    tick();
                end
                check_value("o_full", o_full, 1'b0);
                repeat (SQ_DEPTH - 1) retire_oldest();
                poll_word(op.addr, op.exp_word);
            end
        endcase
    endtask

    initial begin
        data_t got;
        clk              = 1'b0;
        n_rst            = 1'b0;
        i_flush          = 1'b0;
        i_alloc_en       = 1'b0;
        i_alloc_func     = LSU_SB;
        i_alloc_tag      = '0;
        i_alloc_addr     = '0;
        i_alloc_data     = '0;
        i_rob_retire_en  = 1'b0;
        i_rob_retire_tag = '0;
        i_load_en        = 1'b0;
        i_load_addr      = '0;
        rng_state        = 32'd14702;
        next_tag         = '0;
        n_ops_added      = 0;
        error_count      = 0;
        retire_count     = 0;
        ack_count        = 0;
        cycle_count      = 0;
        for (int b = 0; b < RAM_BYTES; b++) begin
            ref_mem[b] = 8'h00;
        end

        // Words 0 and 1 collect several widths and later entries flush, conflict and fill
        add_op(OP_STORE, LSU_SB, 32'h00);
        add_op(OP_STORE, LSU_SB, 32'h03);
        add_op(OP_STORE, LSU_SH, 32'h06);
        add_op(OP_STORE, LSU_SW, 32'h08);
        add_op(OP_STORE, LSU_SH, 32'h00);
        add_op(OP_STORE, LSU_SB, 32'h05);
        add_op(OP_FLUSH, LSU_SW, 32'h10);
        add_op(OP_FLUSH, LSU_SB, 32'h09);
        add_op(OP_BURST, LSU_SW, 32'h14);
        add_op(OP_BURST, LSU_SB, 32'h02);
        add_op(OP_FILL,  LSU_SW, 32'h20);
        add_op(OP_FILL,  LSU_SW, 32'h04);
        add_op(OP_STORE, LSU_SW, 32'h3c);
        build_expected();

        repeat (3) tick();
        n_rst = 1'b1;
        tick();

        for (int i = 0; i < N_OPS; i++) begin
            run_op(ops[i]);
        end

        // The whole RAM is compared with the reference, which also catches flushed data
        for (int w = 0; w < RAM_WORDS; w++) begin
            load_word(addr_t'(w * 4), got);
            check_value("o_load_data", got, ref_word(addr_t'(w * 4)));
        end
        repeat (4) tick();
        check_value("retire ack count", ack_count, retire_count);

        $display("Errors: %0d, retire acks: %0d of %0d", error_count, ack_count, retire_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== lsu_store_unit.f ====
source/lsu_pkg.sv
source/lsu_store_if.sv
source/lsu_data_ram.sv
source/lsu_sq.sv
source/lsu_store_port.sv
source/lsu_store_unit.sv
bench/lsu_store_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the store unit testbench with Verilator and runs it.
# The run counts as passed only if the simulation prints the pass line.
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module lsu_store_unit_tb \
        -f lsu_store_unit.f -o lsu_store_unit_sim \
    && ./obj_dir/lsu_store_unit_sim | tee /dev/stderr | grep -q "^sim passed$" \
    && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }

// ==== source/lsu_data_ram.sv ====
// Small word-organized data RAM behind the store port.
// Writes merge bytes under a per-byte enable, reads return a whole word
// one cycle after the request. The read port has priority, so a write
// that meets a read in the same cycle is not performed.

module lsu_data_ram #(
    parameter int RAM_WORDS = 16
) (
    input  logic           clk,

    input  logic           i_rd_en,
    input  lsu_pkg::addr_t i_rd_addr,
    output lsu_pkg::data_t o_rd_data,

    input  logic           i_wr_en,
    input  lsu_pkg::addr_t i_wr_addr,
    input  logic [3:0]     i_wr_be,
    input  lsu_pkg::data_t i_wr_data
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [31:0]      mem [RAM_WORDS];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    // Byte addresses are folded onto the word array, upper bits wrap
    assign rd_idx = i_rd_addr[IDX_W+1:2];
    assign wr_idx = i_wr_addr[IDX_W+1:2];

    // Zeroed contents so a load of an untouched word is well defined in simulation
    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[rd_idx];
        end
    end

    // Byte-merged write, only when the read port is idle
    always_ff @(posedge clk) begin
        if (i_wr_en && !i_rd_en) begin
            for (int b = 0; b < 4; b++) begin
                if (i_wr_be[b]) begin
                    mem[wr_idx][b*8 +: 8] <= i_wr_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== source/lsu_pkg.sv ====
// Shared widths and encodings for the load/store unit store path.
// Modules refer to these types by scoped name in their port lists and
// take a wildcard import in their bodies when they need the enum values.

package lsu_pkg;

    // Byte address as produced by the address generation unit
    typedef logic [31:0] addr_t;

    // Store data as it sits in the register file, right aligned for
    // byte and halfword stores
    typedef logic [31:0] data_t;

    // ROB tag of a store
    // Unique among all stores that are in flight at the same time
    typedef logic [5:0] tag_t;

    // Width of a store operation
    // The value 2'b11 is never issued by the decoder
    typedef enum logic [1:0] {
        LSU_SB = 2'b00,
        LSU_SH = 2'b01,
        LSU_SW = 2'b10
    } lsu_func_t;

    // State of one store queue slot
    // SQ_INVALID holds nothing and may be allocated
    // SQ_VALID holds a store that is still speculative and may be flushed
    // SQ_NONSPEC holds a store the ROB has retired, waiting to be launched
    // SQ_LAUNCHED holds a store sent to the port, waiting for its update
    typedef enum logic [1:0] {
        SQ_INVALID  = 2'b00,
        SQ_VALID    = 2'b01,
        SQ_NONSPEC  = 2'b10,
        SQ_LAUNCHED = 2'b11
    } sq_state_t;

endpackage

// ==== source/lsu_sq.sv ====
// Store queue that holds stores from allocation until they reach memory.
// Stores become non-speculative when the ROB retires them and are launched
// to the store port one at a time, lowest slot first, so memory is written
// in program order. A flush drops stores that the ROB has not yet retired.

module lsu_sq #(
    parameter int SQ_DEPTH = 4
) (
    input  logic              clk,
    input  logic              n_rst,

    input  logic              i_flush,
    output logic              o_full,

    // New store from the issue stage
    input  logic              i_alloc_en,
    input  lsu_pkg::lsu_func_t i_alloc_func,
    input  lsu_pkg::tag_t     i_alloc_tag,
    input  lsu_pkg::addr_t    i_alloc_addr,
    input  lsu_pkg::data_t    i_alloc_data,

    // ROB retire request, held until the ack comes back
    input  logic              i_rob_retire_en,
    input  lsu_pkg::tag_t     i_rob_retire_tag,
    output logic              o_rob_retire_ack,

    lsu_store_if.sq           store_bus
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(SQ_DEPTH);

    // Slot contents, payload only, the state array carries validity
    lsu_func_t           slot_func  [SQ_DEPTH];
    addr_t               slot_addr  [SQ_DEPTH];
    data_t               slot_data  [SQ_DEPTH];
    tag_t                slot_tag   [SQ_DEPTH];
    sq_state_t           slot_state [SQ_DEPTH];
    sq_state_t           state_next [SQ_DEPTH];

    logic [SQ_DEPTH-1:0] empty;
    logic [SQ_DEPTH-1:0] nonspec;
    logic [SQ_DEPTH-1:0] launched;
    logic [SQ_DEPTH-1:0] tag_match;
    logic [SQ_DEPTH-1:0] alloc_sel;
    logic [SQ_DEPTH-1:0] rob_sel;
    logic [SQ_DEPTH-1:0] launch_sel;
    logic [SQ_DEPTH-1:0] upd_sel;
    logic [IDX_W-1:0]    launch_idx;
    logic                launch_go;
    logic                ack_next;

    // Per-slot status vectors
    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            empty[i]     = (slot_state[i] == SQ_INVALID);
            nonspec[i]   = (slot_state[i] == SQ_NONSPEC);
            launched[i]  = (slot_state[i] == SQ_LAUNCHED);
            // Only a speculative slot may take the retire, which ignores stale tags
            tag_match[i] = (slot_state[i] == SQ_VALID) && (slot_tag[i] == i_rob_retire_tag);
        end
    end

    // Lowest empty slot takes the new store
    assign alloc_sel = {SQ_DEPTH{i_alloc_en}} & (empty & ~(empty - 1'b1));

    // Full already counts a slot being filled this cycle
    assign o_full = ((empty & ~alloc_sel) == '0);

    assign rob_sel = {SQ_DEPTH{i_rob_retire_en}} & tag_match;

    // One store in flight at most keeps memory updates in program order
    // A flush in the same cycle holds the launch back, the slot stays armed
    assign launch_go  = (nonspec != '0) && (launched == '0) && !i_flush;
    assign launch_sel = {SQ_DEPTH{launch_go}} & (nonspec & ~(nonspec - 1'b1));

    assign upd_sel = {SQ_DEPTH{store_bus.update_en}} & store_bus.update_select;

    // Binary index of the launching slot for the payload mux
    always_comb begin
        launch_idx = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (launch_sel[i]) begin
                launch_idx = IDX_W'(i);
            end
        end
    end

    // Ack goes out with the launch, only while the ROB still holds that tag
    // A relaunch after a retry finds the ROB on a later store and stays quiet
    assign ack_next = i_rob_retire_en && launch_go && (slot_tag[launch_idx] == i_rob_retire_tag);

    // Slot state transitions
    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            state_next[i] = slot_state[i];
            case (slot_state[i])
                SQ_INVALID: begin
                    if (alloc_sel[i]) begin
                        state_next[i] = SQ_VALID;
                    end
                end
                SQ_VALID: begin
                    // Flush wins over a retire in the same cycle
                    if (i_flush) begin
                        state_next[i] = SQ_INVALID;
                    end else if (rob_sel[i]) begin
                        state_next[i] = SQ_NONSPEC;
                    end
                end
                SQ_NONSPEC: begin
                    if (launch_sel[i]) begin
                        state_next[i] = SQ_LAUNCHED;
                    end
                end
                SQ_LAUNCHED: begin
                    // Retry re-arms the slot, a clean write frees it
                    if (upd_sel[i]) begin
                        state_next[i] = store_bus.update_retry ? SQ_NONSPEC : SQ_INVALID;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (!n_rst) begin
                slot_state[i] <= SQ_INVALID;
            end else begin
                slot_state[i] <= state_next[i];
            end
        end
    end

    // Store payload is captured on allocation
    always_ff @(posedge clk) begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (alloc_sel[i]) begin
                slot_func[i] <= i_alloc_func;
                slot_addr[i] <= i_alloc_addr;
                slot_data[i] <= i_alloc_data;
                slot_tag[i]  <= i_alloc_tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            store_bus.launch_en <= 1'b0;
            o_rob_retire_ack    <= 1'b0;
        end else begin
            store_bus.launch_en <= launch_go;
            o_rob_retire_ack    <= ack_next;
        end
    end

    // Launch payload, qualified downstream by launch_en
    always_ff @(posedge clk) begin
        if (launch_go) begin
            store_bus.launch_select <= launch_sel;
            store_bus.launch_func   <= slot_func[launch_idx];
            store_bus.launch_addr   <= slot_addr[launch_idx];
            store_bus.launch_tag    <= slot_tag[launch_idx];
            store_bus.launch_data   <= slot_data[launch_idx];
        end
    end

endmodule

// ==== source/lsu_store_if.sv ====
// Link between the store queue and the store port.
// The queue drives a registered launch of one store, and the port answers
// each launch with a registered update one cycle later, which either frees
// the slot or asks for a retry.

interface lsu_store_if #(
    parameter int SQ_DEPTH = 4
);
    import lsu_pkg::*;

    // Launch fields, registered in the queue
    logic                launch_en;
    logic [SQ_DEPTH-1:0] launch_select;
    lsu_func_t           launch_func;
    addr_t               launch_addr;
    tag_t                launch_tag;
    data_t               launch_data;

    // Update reply, registered in the port
    // The select is one-hot and echoes the launched slot
    logic                update_en;
    logic [SQ_DEPTH-1:0] update_select;
    logic                update_retry;

    modport sq (
        output launch_en, launch_select, launch_func, launch_addr, launch_tag, launch_data,
        input  update_en, update_select, update_retry
    );

    modport port (
        input  launch_en, launch_select, launch_func, launch_addr, launch_tag, launch_data,
        output update_en, update_select, update_retry
    );

endinterface

// ==== source/lsu_store_port.sv ====
// Store port between the store queue and the data RAM.
// A launched store is turned into byte enables and lane-aligned data and
// written one cycle after launch, unless a load holds the RAM port in that
// cycle. Either way an update goes back to the queue, with retry set when
// the write was dropped.

module lsu_store_port #(
    parameter int RAM_WORDS = 16
) (
    input  logic           clk,
    input  logic           n_rst,

    // Load read port, it always wins the RAM
    input  logic           i_load_en,
    input  lsu_pkg::addr_t i_load_addr,
    output lsu_pkg::data_t o_load_data,

    lsu_store_if.port      store_bus
);
    import lsu_pkg::*;

    logic [3:0] wr_be;
    data_t      wr_data;
    logic       wr_en;
    logic       conflict;

    // Byte enables and lane alignment from the width and the low address bits
    // Halfwords are assumed aligned, addr[0] is ignored for them
    always_comb begin
        case (store_bus.launch_func)
            LSU_SB: begin
                wr_be   = 4'b0001 << store_bus.launch_addr[1:0];
                wr_data = store_bus.launch_data << {store_bus.launch_addr[1:0], 3'b000};
            end
            LSU_SH: begin
                wr_be   = store_bus.launch_addr[1] ? 4'b1100 : 4'b0011;
                wr_data = store_bus.launch_data << {store_bus.launch_addr[1], 4'b0000};
            end
            default: begin
                wr_be   = 4'b1111;
                wr_data = store_bus.launch_data;
            end
        endcase
    end

    // A load in the same cycle takes the port and the store must come back later
    assign conflict = store_bus.launch_en && i_load_en;
    assign wr_en    = store_bus.launch_en && !i_load_en;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            store_bus.update_en <= 1'b0;
        end else begin
            store_bus.update_en <= store_bus.launch_en;
        end
    end

    // Reply payload, only looked at while update_en is high
    always_ff @(posedge clk) begin
        store_bus.update_select <= store_bus.launch_select;
        store_bus.update_retry  <= conflict;
    end

    lsu_data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) i_lsu_data_ram (
        .clk       (clk),
        .i_rd_en   (i_load_en),
        .i_rd_addr (i_load_addr),
        .o_rd_data (o_load_data),
        .i_wr_en   (wr_en),
        .i_wr_addr (store_bus.launch_addr),
        .i_wr_be   (wr_be),
        .i_wr_data (wr_data)
    );

endmodule

// ==== source/lsu_store_unit.sv ====
// Top level of the store path: store queue, store port and data RAM.
// Stores are allocated, retired by the ROB and written to the RAM in
// program order. Loads read the RAM directly and preempt a pending store.

module lsu_store_unit #(
    parameter int SQ_DEPTH  = 4,
    parameter int RAM_WORDS = 16
) (
    input  logic               clk,
    input  logic               n_rst,

    input  logic               i_flush,
    output logic               o_full,

    // Store allocation, not allowed while o_full is high
    input  logic               i_alloc_en,
    input  lsu_pkg::lsu_func_t i_alloc_func,
    input  lsu_pkg::tag_t      i_alloc_tag,
    input  lsu_pkg::addr_t     i_alloc_addr,
    input  lsu_pkg::data_t     i_alloc_data,

    // ROB retire, held until the ack pulse
    input  logic               i_rob_retire_en,
    input  lsu_pkg::tag_t      i_rob_retire_tag,
    output logic               o_rob_retire_ack,

    // Load, data valid one cycle later
    input  logic               i_load_en,
    input  lsu_pkg::addr_t     i_load_addr,
    output lsu_pkg::data_t     o_load_data
);

    lsu_store_if #(
        .SQ_DEPTH (SQ_DEPTH)
    ) store_bus ();

    lsu_sq #(
        .SQ_DEPTH (SQ_DEPTH)
    ) i_lsu_sq (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .o_full           (o_full),
        .i_alloc_en       (i_alloc_en),
        .i_alloc_func     (i_alloc_func),
        .i_alloc_tag      (i_alloc_tag),
        .i_alloc_addr     (i_alloc_addr),
        .i_alloc_data     (i_alloc_data),
        .i_rob_retire_en  (i_rob_retire_en),
        .i_rob_retire_tag (i_rob_retire_tag),
        .o_rob_retire_ack (o_rob_retire_ack),
        .store_bus        (store_bus.sq)
    );

    // The port owns the RAM and arbitrates loads against launched stores
    lsu_store_port #(
        .RAM_WORDS (RAM_WORDS)
    ) i_lsu_store_port (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_load_en   (i_load_en),
        .i_load_addr (i_load_addr),
        .o_load_data (o_load_data),
        .store_bus   (store_bus.port)
    );

endmodule
